// ==== cache.f ====
cache_pkg.sv
cache_mem.sv
cache_fifo.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

// ==== Makefile ====
TOP := tb_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cache.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cache.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;

  logic                              clk_i;
  logic                              rst_i;
  logic                              s_cyc_i;
  logic                              s_stb_i;
  logic                              s_we_i;
  logic [cache_pkg::addr_width-1:0]  s_adr_i;
  logic [cache_pkg::sel_width-1:0]   s_sel_i;
  logic [cache_pkg::data_width-1:0]  s_dat_i;
  logic                              stats_stb_i;
  logic [cache_pkg::data_width-1:0]  s_dat_o;
  logic                              s_ack_o;
  logic                              m_cyc_o;
  logic                              m_stb_o;
  logic                              m_we_o;
  logic [cache_pkg::addr_width-1:0]  m_adr_o;
  logic [cache_pkg::sel_width-1:0]   m_sel_o;
  logic [cache_pkg::data_width-1:0]  m_dat_o;
  logic [cache_pkg::data_width-1:0]  m_dat_i;
  logic                              m_ack_i;

  logic [31:0]                       stim_lfsr;
  logic [31:0]                       mem_lfsr;

  // flat expected memory and the memory slave's own storage
  logic [cache_pkg::data_width-1:0]  flat_mem  [logic [cache_pkg::addr_width-1:0]];
  logic [cache_pkg::data_width-1:0]  slave_mem [logic [cache_pkg::addr_width-1:0]];
  logic                              touched   [logic [cache_pkg::addr_width-1:0]];

  logic                              mdl_valid [2][cache_pkg::num_rows];
  logic [cache_pkg::tag_width-1:0]   mdl_tag   [2][cache_pkg::num_rows];
  logic [cache_pkg::line_words-1:0]  mdl_dirty [2][cache_pkg::num_rows];
  logic                              mdl_lru   [cache_pkg::num_rows];
  logic [31:0]                       mdl_hits;
  logic [31:0]                       mdl_flushes;
  logic [31:0]                       mdl_fills;

  // expected master beats in bus order
  logic                              exp_we  [$];
  logic [cache_pkg::addr_width-1:0]  exp_adr [$];
  logic [cache_pkg::data_width-1:0]  exp_dat [$];

  cache_top i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_cyc_i     (s_cyc_i),
    .s_stb_i     (s_stb_i),
    .s_we_i      (s_we_i),
    .s_adr_i     (s_adr_i),
    .s_sel_i     (s_sel_i),
    .s_dat_i     (s_dat_i),
    .stats_stb_i (stats_stb_i),
    .s_dat_o     (s_dat_o),
    .s_ack_o     (s_ack_o),
    .m_cyc_o     (m_cyc_o),
    .m_stb_o     (m_stb_o),
    .m_we_o      (m_we_o),
    .m_adr_o     (m_adr_o),
    .m_sel_o     (m_sel_o),
    .m_dat_o     (m_dat_o),
    .m_dat_i     (m_dat_i),
    .m_ack_i     (m_ack_i)
  );

  bind cache_ctrl cache_checker u_checker (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .state_i (state_q),
    .m_cyc_i (m_cyc_o),
    .m_stb_i (m_stb_o),
    .m_we_i  (m_we_o),
    .m_adr_i (m_adr_o),
    .m_ack_i (m_ack_i),
    .s_ack_i (s_ack_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb    = state[31] ^ state[21] ^ state[1] ^ state[0]; // taps 32 22 2 1
      state = {state[30:0], fb};
      val   = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] init_word(input logic [cache_pkg::addr_width-1:0] adr);
    return ({7'b0, adr} * 32'h9e3779b1) ^ 32'h0badc0de;
  endfunction

  function automatic logic [31:0] flat_read(input logic [cache_pkg::addr_width-1:0] adr);
    return flat_mem.exists(adr) ? flat_mem[adr] : init_word(adr);
  endfunction

  function automatic logic [31:0] slave_read(input logic [cache_pkg::addr_width-1:0] adr);
    return slave_mem.exists(adr) ? slave_mem[adr] : init_word(adr);
  endfunction

  // 4 tags x 4 indices x 4 words
  function automatic logic [cache_pkg::addr_width-1:0] random_addr();
    logic [1:0] t;
    logic [1:0] i;
    logic [1:0] w;
    t = 2'(take_bits(stim_lfsr, 2));
    i = 2'(take_bits(stim_lfsr, 2));
    w = 2'(take_bits(stim_lfsr, 2));
    return {t, 11'h0f3, i, 8'h5c, w};
  endfunction

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [cache_pkg::data_width-1:0] exp_val,
                            input logic [cache_pkg::data_width-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s expected %h actual %h", name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [cache_pkg::addr_width-1:0] exp_val,
                            input logic [cache_pkg::addr_width-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s expected %h actual %h", name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  task automatic check_sel(input string name, input logic [cache_pkg::sel_width-1:0] exp_val,
                           input logic [cache_pkg::sel_width-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s expected %h actual %h", name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s expected %0d actual %0d", name, exp_val, act_val);
      stop_on_failure();
    end
  endtask

  // one request in queue order with its expected bursts
  task automatic model_access(input logic we, input logic [cache_pkg::addr_width-1:0] adr,
                              input logic [3:0] sel, input logic [31:0] dat,
                              output logic [31:0] rdat);
    logic [12:0] tag;
    logic [9:0]  idx;
    logic [1:0]  wrd;
    logic        way;
    logic        found;
    logic [31:0] word;
    tag   = adr[24:12];
    idx   = adr[11:2];
    wrd   = adr[1:0];
    found = 1'b0;
    way   = 1'b0;
    for (int k = 0; k < 2; k++) begin
      if (mdl_valid[k][idx] && (mdl_tag[k][idx] == tag)) begin
        found = 1'b1;
        way   = k[0];
      end
    end
    if (!found) begin
      way = mdl_lru[idx];
      if (mdl_valid[way][idx] && (mdl_dirty[way][idx] != 4'b0)) begin
        mdl_flushes++;
        for (int b = 0; b < 4; b++) begin
          exp_we.push_back(1'b1);
          exp_adr.push_back({mdl_tag[way][idx], idx, 2'(b)});
          exp_dat.push_back(flat_read({mdl_tag[way][idx], idx, 2'(b)}));
        end
      end
      mdl_fills++;
      for (int b = 0; b < 4; b++) begin
        exp_we.push_back(1'b0);
        exp_adr.push_back({tag, idx, 2'(b)});
        exp_dat.push_back(32'h0);
      end
      mdl_valid[way][idx] = 1'b1;
      mdl_tag[way][idx]   = tag;
      mdl_dirty[way][idx] = 4'b0;
    end
    mdl_hits++; // the replay after a fill is a hit too
    mdl_lru[idx] = ~way;
    word = flat_read(adr);
    if (we) begin
      mdl_dirty[way][idx][wrd] = 1'b1;
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          word[8*b +: 8] = dat[8*b +: 8];
        end
      end
      flat_mem[adr] = word;
    end
    rdat = word;
  endtask

  task automatic bus_request(input logic we, input logic stats,
                             input logic [cache_pkg::addr_width-1:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat,
                             output logic [31:0] rdat);
    int cycles;
    s_cyc_i     = 1'b1;
    s_stb_i     = 1'b1;
    s_we_i      = we;
    stats_stb_i = stats;
    s_adr_i     = adr;
    s_sel_i     = sel;
    s_dat_i     = dat;
    cycles      = 0;
    @(posedge clk_i);
    #2;
    while (!s_ack_o) begin
      cycles++;
      if (cycles >= 5000) begin
        $display("no slave ack within 5000 cycles for address %h", adr);
        stop_on_failure();
      end
      @(posedge clk_i);
      #2;
    end
    rdat        = s_dat_o;
    s_cyc_i     = 1'b0;
    s_stb_i     = 1'b0;
    s_we_i      = 1'b0;
    stats_stb_i = 1'b0;
  endtask

  task automatic do_write(input logic [cache_pkg::addr_width-1:0] adr, input logic [3:0] sel,
                          input logic [31:0] dat);
    logic [31:0] unused;
    model_access(1'b1, adr, sel, dat, unused);
    bus_request(1'b1, 1'b0, adr, sel, dat, unused);
  endtask

  task automatic do_read(input logic [cache_pkg::addr_width-1:0] adr, input string name);
    logic [31:0] exp_val;
    logic [31:0] act_val;
    model_access(1'b0, adr, 4'h0, 32'h0, exp_val);
    bus_request(1'b0, 1'b0, adr, 4'h0, 32'h0, act_val);
    check_data(name, exp_val, act_val);
  endtask

  task automatic read_stat(input logic [3:0] offset, input logic [31:0] exp_val,
                           input string name);
    logic [31:0] act_val;
    bus_request(1'b0, 1'b1, 25'(offset), 4'h0, 32'h0, act_val);
    check_count(name, exp_val, act_val);
  endtask

  // memory slave with 0 to 3 wait states per beat
  initial begin : memory_slave
    int   wait_left;
    logic beat_open;
    wait_left = 0;
    beat_open = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      if (m_ack_i) begin
        m_ack_i   = 1'b0;
        beat_open = 1'b0;
      end else if (m_cyc_o) begin
        if (!beat_open) begin
          beat_open = 1'b1;
          wait_left = int'(take_bits(mem_lfsr, 2));
          if (exp_we.size() == 0) begin
            $display("unexpected memory beat at address %h", m_adr_o);
            stop_on_failure();
          end
          if (exp_we[0] !== m_we_o) begin
            $display("memory beat at address %h has the wrong direction", m_adr_o);
            stop_on_failure();
          end
          check_addr("burst beat address", exp_adr[0], m_adr_o);
          check_sel("burst beat byte selects", '1, m_sel_o);
          if (m_we_o) begin
            check_data("writeback beat data", exp_dat[0], m_dat_o);
          end
          void'(exp_we.pop_front());
          void'(exp_adr.pop_front());
          void'(exp_dat.pop_front());
        end
        if (wait_left == 0) begin
          if (m_we_o) begin
            slave_mem[m_adr_o] = m_dat_o;
          end else begin
            m_dat_i = slave_read(m_adr_o);
          end
          m_ack_i = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin : stimulus
    logic [cache_pkg::addr_width-1:0] adr;
    logic [cache_pkg::addr_width-1:0] addr_list [$];
    logic [3:0]                       sel;
    logic [31:0]                      dat;
    logic [1:0]                       op;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    s_cyc_i     = 1'b0;
    s_stb_i     = 1'b0;
    s_we_i      = 1'b0;
    s_adr_i     = '0;
    s_sel_i     = '0;
    s_dat_i     = '0;
    stats_stb_i = 1'b0;
    m_dat_i     = '0;
    m_ack_i     = 1'b0;
    stim_lfsr   = 32'h156fbfdb;
    mem_lfsr    = 32'h156fbfdb;
    mdl_hits    = '0;
    mdl_flushes = '0;
    mdl_fills   = '0;
    for (int r = 0; r < cache_pkg::num_rows; r++) begin
      mdl_valid[0][r] = 1'b0;
      mdl_valid[1][r] = 1'b0;
      mdl_tag[0][r]   = '0;
      mdl_tag[1][r]   = '0;
      mdl_dirty[0][r] = '0;
      mdl_dirty[1][r] = '0;
      mdl_lru[r]      = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    adr = random_addr();
    touched[adr] = 1'b1;
    do_read(adr, "first read after init"); // waits out the init sweep

    for (int n = 0; n < 400; n++) begin
      adr = random_addr();
      touched[adr] = 1'b1;
      op = 2'(take_bits(stim_lfsr, 2));
      if (op == 2'd0) begin
        do_read(adr, "random read");
      end else begin
        sel = 4'(take_bits(stim_lfsr, 4));
        dat = take_bits(stim_lfsr, 32);
        do_write(adr, sel, dat);
        if (op == 2'd3) begin
          do_read(adr, "byte merge read back");
        end
      end
    end

    read_stat(cache_pkg::stat_hit, mdl_hits, "hit counter");
    read_stat(cache_pkg::stat_flush, mdl_flushes, "flush counter");
    read_stat(cache_pkg::stat_fill, mdl_fills, "fill counter");

    foreach (touched[a]) begin
      addr_list.push_back(a);
    end
    foreach (addr_list[k]) begin
      do_read(addr_list[k], "final sweep read");
    end

    if (exp_we.size() != 0) begin
      $display("%0d expected memory beats never appeared", exp_we.size());
      stop_on_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== cache_checker.sv ====
`timescale 1ns/1ps

module cache_checker (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  cache_pkg::ctrl_state_e            state_i,
  input  logic                              m_cyc_i,
  input  logic                              m_stb_i,
  input  logic                              m_we_i,
  input  logic [cache_pkg::addr_width-1:0]  m_adr_i,
  input  logic                              m_ack_i,
  input  logic                              s_ack_i
);

  a_stb_follows_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    m_stb_i == m_cyc_i)
    else $error("m_stb_o differs from m_cyc_o");

  a_ack_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    s_ack_i |=> !s_ack_i)
    else $error("s_ack_o high in two consecutive cycles");

  a_quiet_during_init: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_i == cache_pkg::init) |-> !m_cyc_i)
    else $error("memory bus cycle started during the init sweep");

  // a waiting beat keeps address and direction until acked
  a_beat_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (m_cyc_i && !m_ack_i) |=> (m_cyc_i && $stable(m_adr_i) && $stable(m_we_i)))
    else $error("memory beat changed before m_ack_i");

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              s_cyc_i,
  input  logic                              s_stb_i,
  input  logic                              s_we_i,
  input  logic [cache_pkg::addr_width-1:0]  s_adr_i,
  input  logic [cache_pkg::sel_width-1:0]   s_sel_i,
  input  logic [cache_pkg::data_width-1:0]  s_dat_i,
  input  logic                              stats_stb_i,
  output logic [cache_pkg::data_width-1:0]  s_dat_o,
  output logic                              s_ack_o,
  output logic                              m_cyc_o,
  output logic                              m_stb_o,
  output logic                              m_we_o,
  output logic [cache_pkg::addr_width-1:0]  m_adr_o,
  output logic [cache_pkg::sel_width-1:0]   m_sel_o,
  output logic [cache_pkg::data_width-1:0]  m_dat_o,
  input  logic [cache_pkg::data_width-1:0]  m_dat_i,
  input  logic                              m_ack_i
);

  logic                                     fifo_wr;
  logic                                     fifo_rd;
  logic                                     fifo_empty;
  logic                                     fifo_full;
  logic [cache_pkg::fifo_width-1:0]         fifo_wdata;
  logic [cache_pkg::fifo_width-1:0]         fifo_q;
  logic [cache_pkg::index_width-1:0]        mem_addr;
  logic [1:0]                               mem_wren;
  logic [1:0][cache_pkg::row_width-1:0]     mem_wdata;
  logic [1:0][cache_pkg::row_width-1:0]     mem_rdata;

  cache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_cyc_i      (s_cyc_i),
    .s_stb_i      (s_stb_i),
    .s_we_i       (s_we_i),
    .s_adr_i      (s_adr_i),
    .s_sel_i      (s_sel_i),
    .s_dat_i      (s_dat_i),
    .stats_stb_i  (stats_stb_i),
    .s_dat_o      (s_dat_o),
    .s_ack_o      (s_ack_o),
    .m_cyc_o      (m_cyc_o),
    .m_stb_o      (m_stb_o),
    .m_we_o       (m_we_o),
    .m_adr_o      (m_adr_o),
    .m_sel_o      (m_sel_o),
    .m_dat_o      (m_dat_o),
    .m_dat_i      (m_dat_i),
    .m_ack_i      (m_ack_i),
    .fifo_wr_o    (fifo_wr),
    .fifo_wdata_o (fifo_wdata),
    .fifo_rd_o    (fifo_rd),
    .fifo_empty_i (fifo_empty),
    .fifo_full_i  (fifo_full),
    .fifo_q_i     (fifo_q),
    .mem_addr_o   (mem_addr),
    .mem_wren_o   (mem_wren),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata)
  );

  cache_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wr_i    (fifo_wr),
    .wdata_i (fifo_wdata),
    .rd_i    (fifo_rd),
    .rdata_o (fifo_q),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  cache_mem u_way0 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .addr_i  (mem_addr),
    .wren_i  (mem_wren[0]),
    .wdata_i (mem_wdata[0]),
    .rdata_o (mem_rdata[0])
  );

  cache_mem u_way1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .addr_i  (mem_addr),
    .wren_i  (mem_wren[1]),
    .wdata_i (mem_wdata[1]),
    .rdata_o (mem_rdata[1])
  );

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        s_cyc_i,
  input  logic                                        s_stb_i,
  input  logic                                        s_we_i,
  input  logic [cache_pkg::addr_width-1:0]            s_adr_i,
  input  logic [cache_pkg::sel_width-1:0]             s_sel_i,
  input  logic [cache_pkg::data_width-1:0]            s_dat_i,
  input  logic                                        stats_stb_i,
  output logic [cache_pkg::data_width-1:0]            s_dat_o,
  output logic                                        s_ack_o,
  output logic                                        m_cyc_o,
  output logic                                        m_stb_o,
  output logic                                        m_we_o,
  output logic [cache_pkg::addr_width-1:0]            m_adr_o,
  output logic [cache_pkg::sel_width-1:0]             m_sel_o,
  output logic [cache_pkg::data_width-1:0]            m_dat_o,
  input  logic [cache_pkg::data_width-1:0]            m_dat_i,
  input  logic                                        m_ack_i,
  output logic                                        fifo_wr_o,
  output logic [cache_pkg::fifo_width-1:0]            fifo_wdata_o,
  output logic                                        fifo_rd_o,
  input  logic                                        fifo_empty_i,
  input  logic                                        fifo_full_i,
  input  logic [cache_pkg::fifo_width-1:0]            fifo_q_i,
  output logic [cache_pkg::index_width-1:0]           mem_addr_o,
  output logic [1:0]                                  mem_wren_o,
  output logic [1:0][cache_pkg::row_width-1:0]        mem_wdata_o,
  input  logic [1:0][cache_pkg::row_width-1:0]        mem_rdata_i
);

  cache_pkg::ctrl_state_e                 state_q;
  cache_pkg::ctrl_state_e                 state_d;
  logic [cache_pkg::index_width-1:0]      init_cnt_q;
  logic [cache_pkg::offset_width-1:0]     beat_q;
  logic                                   req_we_q;
  logic [cache_pkg::addr_width-1:0]       req_adr_q;
  logic [cache_pkg::data_width-1:0]       req_dat_q;
  logic [cache_pkg::sel_width-1:0]        req_sel_q;
  logic                                   hit_way_q;
  logic                                   victim_q;
  cache_pkg::line_data_u                  fill_buf_q;
  logic                                   lru_q [cache_pkg::num_rows];
  logic [cache_pkg::data_width-1:0]       hit_cnt_q;
  logic [cache_pkg::data_width-1:0]       flush_cnt_q;
  logic [cache_pkg::data_width-1:0]       fill_cnt_q;
  logic                                   ack_q;
  logic                                   rd_wait_q;
  logic                                   pend_stats_q;
  logic                                   stats_done_q;

  logic                                   accept;
  logic                                   stats_req;
  logic [cache_pkg::data_width-1:0]       stat_val;
  logic [cache_pkg::tag_width-1:0]        req_tag;
  logic [cache_pkg::index_width-1:0]      req_idx;
  logic [cache_pkg::offset_width-1:0]     req_word;
  logic [1:0]                             way_hit;
  logic                                   sel_way;
  logic [cache_pkg::row_width-1:0]        cur_row;
  logic [cache_pkg::tag_width-1:0]        cur_tag;
  logic [cache_pkg::line_words-1:0]       cur_dirty;
  cache_pkg::line_data_u                  cur_data;
  cache_pkg::line_data_u                  merged;
  logic [cache_pkg::line_words-1:0]       word_mask;
  logic [cache_pkg::row_width-1:0]        wr_row;

  assign req_tag  = req_adr_q[cache_pkg::addr_width-1 -: cache_pkg::tag_width];
  assign req_idx  = req_adr_q[cache_pkg::offset_width +: cache_pkg::index_width];
  assign req_word = req_adr_q[cache_pkg::offset_width-1:0];

  // slave side acceptance
  assign accept       = s_cyc_i & s_stb_i & ~ack_q & ~rd_wait_q & (stats_stb_i | ~fifo_full_i);
  assign fifo_wr_o    = accept & ~stats_stb_i;
  assign fifo_wdata_o = {s_we_i, s_adr_i, s_dat_i, s_sel_i};
  assign s_ack_o      = ack_q;
  assign stats_req    = s_cyc_i & s_stb_i & stats_stb_i & ~ack_q & fifo_empty_i;

  always_comb begin
    case (s_adr_i[3:0])
      cache_pkg::stat_hit:   stat_val = hit_cnt_q;
      cache_pkg::stat_flush: stat_val = flush_cnt_q;
      cache_pkg::stat_fill:  stat_val = fill_cnt_q;
      default:               stat_val = '0;
    endcase
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = mem_rdata_i[w][cache_pkg::row_valid_bit] &&
                   (mem_rdata_i[w][cache_pkg::row_tag_lsb +: cache_pkg::tag_width] == req_tag);
    end
  end

  assign sel_way = (state_q == cache_pkg::hit) ? hit_way_q : victim_q;

  // byte merge of the write data into the hit row
  always_comb begin
    cur_row   = mem_rdata_i[sel_way];
    cur_tag   = cur_row[cache_pkg::row_tag_lsb +: cache_pkg::tag_width];
    cur_dirty = cur_row[cache_pkg::row_dirty_lsb +: cache_pkg::line_words];
    cur_data  = cur_row[cache_pkg::line_width-1:0];
    merged    = cur_data;
    for (int b = 0; b < cache_pkg::sel_width; b++) begin
      if (req_sel_q[b]) begin
        merged.bytes[req_word * cache_pkg::sel_width + b] = req_dat_q[8*b +: 8];
      end
    end
    word_mask           = '0;
    word_mask[req_word] = 1'b1;
  end

  assign mem_addr_o  = (state_q == cache_pkg::init) ? init_cnt_q : req_idx;
  assign mem_wdata_o = {wr_row, wr_row};
  assign m_stb_o     = m_cyc_o;
  assign m_sel_o     = '1;

  always_comb begin
    state_d    = state_q;
    fifo_rd_o  = 1'b0;
    mem_wren_o = '0;
    wr_row     = '0; // init sweep writes an invalid row
    m_cyc_o    = 1'b0;
    m_we_o     = 1'b0;
    m_adr_o    = '0;
    m_dat_o    = '0;
    case (state_q)
      cache_pkg::init: begin
        mem_wren_o = 2'b11;
        if (init_cnt_q == '0) begin
          state_d = cache_pkg::idle;
        end
      end
      cache_pkg::idle: begin
        if (stats_req) begin
          state_d = cache_pkg::done;
        end else if (!fifo_empty_i) begin
          fifo_rd_o = 1'b1;
          state_d   = cache_pkg::lookup;
        end
      end
      cache_pkg::lookup:  state_d = cache_pkg::compare; // rows arrive next cycle
      cache_pkg::compare: state_d = (|way_hit) ? cache_pkg::hit : cache_pkg::miss;
      cache_pkg::hit: begin
        wr_row                = {1'b1, cur_dirty | word_mask, cur_tag, merged};
        mem_wren_o[hit_way_q] = req_we_q;
        state_d               = cache_pkg::done;
      end
      cache_pkg::miss: begin
        if (cur_row[cache_pkg::row_valid_bit] && (|cur_dirty)) begin
          state_d = cache_pkg::flush;
        end else begin
          state_d = cache_pkg::fill;
        end
      end
      cache_pkg::flush: begin
        m_cyc_o = 1'b1;
        m_we_o  = 1'b1;
        m_adr_o = {cur_tag, req_idx, beat_q};
        m_dat_o = cur_data.words[beat_q];
        if (m_ack_i && (&beat_q)) begin
          state_d = cache_pkg::flush_done;
        end
      end
      cache_pkg::flush_done: state_d = cache_pkg::fill;
      cache_pkg::fill: begin
        m_cyc_o = 1'b1;
        m_adr_o = {req_tag, req_idx, beat_q};
        if (m_ack_i && (&beat_q)) begin
          state_d = cache_pkg::fill_done;
        end
      end
      cache_pkg::fill_done: begin
        wr_row               = {1'b1, {cache_pkg::line_words{1'b0}}, req_tag, fill_buf_q};
        mem_wren_o[victim_q] = 1'b1;
        state_d              = cache_pkg::lookup; // replay
      end
      default: state_d = cache_pkg::idle;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q      <= cache_pkg::init;
      init_cnt_q   <= '1;
      beat_q       <= '0;
      hit_way_q    <= 1'b0;
      victim_q     <= 1'b0;
      hit_cnt_q    <= '0;
      flush_cnt_q  <= '0;
      fill_cnt_q   <= '0;
      ack_q        <= 1'b0;
      rd_wait_q    <= 1'b0;
      pend_stats_q <= 1'b0;
      stats_done_q <= 1'b0;
      s_dat_o      <= '0;
    end else begin
      state_q <= state_d;
      ack_q   <= 1'b0;
      if (accept) begin
        if (s_we_i && !stats_stb_i) begin
          ack_q <= 1'b1; // posted write
        end else begin
          rd_wait_q    <= 1'b1;
          pend_stats_q <= stats_stb_i;
        end
      end
      // read acks once its own entry is done and nothing is left queued
      if (rd_wait_q && (state_q == cache_pkg::done) && fifo_empty_i &&
          (stats_done_q == pend_stats_q)) begin
        rd_wait_q <= 1'b0;
        ack_q     <= 1'b1;
      end
      case (state_q)
        cache_pkg::init: init_cnt_q <= init_cnt_q - 1'b1;
        cache_pkg::idle: begin
          if (stats_req) begin
            stats_done_q <= 1'b1;
            s_dat_o      <= stat_val;
          end else if (!fifo_empty_i) begin
            stats_done_q <= 1'b0;
          end
        end
        cache_pkg::compare: begin
          hit_way_q <= way_hit[1];
          victim_q  <= lru_q[req_idx];
        end
        cache_pkg::hit: begin
          hit_cnt_q <= hit_cnt_q + 1'b1;
          if (!req_we_q) begin
            s_dat_o <= cur_data.words[req_word];
          end
        end
        cache_pkg::flush, cache_pkg::fill: begin
          if (m_ack_i) begin
            beat_q <= beat_q + 1'b1; // back to zero after the last beat
          end
        end
        cache_pkg::flush_done: flush_cnt_q <= flush_cnt_q + 1'b1;
        cache_pkg::fill_done:  fill_cnt_q <= fill_cnt_q + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_rd_o) begin
      {req_we_q, req_adr_q, req_dat_q, req_sel_q} <= fifo_q_i;
    end
    if ((state_q == cache_pkg::fill) && m_ack_i) begin
      fill_buf_q.words[beat_q] <= m_dat_i;
    end
  end

  // per-set lru, points at the way to evict
  always_ff @(posedge clk_i) begin
    if (state_q == cache_pkg::init) begin
      lru_q[init_cnt_q] <= 1'b0;
    end else if (state_q == cache_pkg::hit) begin
      lru_q[req_idx] <= ~hit_way_q;
    end
  end

endmodule

// ==== cache_fifo.sv ====
`timescale 1ns/1ps

module cache_fifo (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              wr_i,
  input  logic [cache_pkg::fifo_width-1:0]  wdata_i,
  input  logic                              rd_i,
  output logic [cache_pkg::fifo_width-1:0]  rdata_o,
  output logic                              full_o,
  output logic                              empty_o
);

  logic [cache_pkg::fifo_width-1:0]      buf_q [cache_pkg::fifo_depth];
  logic [cache_pkg::fifo_ptr_width-1:0]  wr_ptr_q;
  logic [cache_pkg::fifo_ptr_width-1:0]  rd_ptr_q;
  logic [cache_pkg::fifo_ptr_width:0]    count_q;
  logic                                  do_wr;
  logic                                  do_rd;

  assign full_o  = (count_q == cache_pkg::fifo_depth);
  assign empty_o = (count_q == '0);
  assign do_wr   = wr_i & ~full_o;
  assign do_rd   = rd_i & ~empty_o;
  assign rdata_o = buf_q[rd_ptr_q]; // head entry, no read latency

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      buf_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== cache_mem.sv ====
`timescale 1ns/1ps

module cache_mem (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [cache_pkg::index_width-1:0]  addr_i,
  input  logic                               wren_i,
  input  logic [cache_pkg::row_width-1:0]    wdata_i,
  output logic [cache_pkg::row_width-1:0]    rdata_o
);

  logic [cache_pkg::row_width-1:0] mem_q [cache_pkg::num_rows];

  always_ff @(posedge clk_i) begin
    if (wren_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // registered read port, new data wins on a write
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (wren_i) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

  localparam int addr_width     = 25;
  localparam int tag_width      = 13;
  localparam int index_width    = 10;
  localparam int offset_width   = 2;
  localparam int line_words     = 4;
  localparam int data_width     = 32;
  localparam int sel_width      = data_width / 8;
  localparam int line_width     = line_words * data_width;
  localparam int num_rows       = 1 << index_width;

  // row layout, valid on top and data at the bottom
  localparam int row_tag_lsb    = line_width;
  localparam int row_dirty_lsb  = row_tag_lsb + tag_width;
  localparam int row_valid_bit  = row_dirty_lsb + line_words;
  localparam int row_width      = row_valid_bit + 1; // 146

  localparam int fifo_width     = 1 + addr_width + data_width + sel_width; // 62
  localparam int fifo_depth     = 4;
  localparam int fifo_ptr_width = 2;

  localparam logic [3:0] stat_hit   = 4'd0;
  localparam logic [3:0] stat_flush = 4'd1;
  localparam logic [3:0] stat_fill  = 4'd2;

  typedef enum logic [3:0] {
    init, idle, lookup, compare, hit, miss,
    flush, flush_done, fill, fill_done, done
  } ctrl_state_e;

  typedef union packed {
    logic [line_words-1:0][data_width-1:0]          words;
    logic [line_words*sel_width-1:0][7:0]            bytes;
  } line_data_u;

endpackage
